//--- source/padLoader_defines.svh
// Pad loader width and depth macros

`ifndef PADLOADER_DEFINES_SVH
`define PADLOADER_DEFINES_SVH

// ========================================
// Pad stream
// ========================================

// One pad word, also one buffer word
`define PAD_WIDTH 32

// ========================================
// Global buffer
// ========================================

`define BUF_ADDR_WIDTH 8
`define BUF_DEPTH 256

// Run length field, a run is count plus one words
`define CNT_WIDTH 8

`endif

//--- source/padLoaderPkg.sv
// Pad loader shared types

`default_nettype none

`include "padLoader_defines.svh"

package padLoaderPkg;

    // ========================================
    // Instruction word
    // ========================================

    // Codes 2 and 3 are unused, those packets get dropped
    typedef enum logic [1:0] {
        OP_WRITE = 2'd0,
        OP_READ  = 2'd1
    } opcode_e;

    typedef struct packed {
        opcode_e                                            op;
        logic [`PAD_WIDTH-2-`BUF_ADDR_WIDTH-`CNT_WIDTH-1:0] reserved;
        logic [`BUF_ADDR_WIDTH-1:0]                         addr;
        logic [`CNT_WIDTH-1:0]                              count;
    } instrWord_t;

    // First beat reads as instr, the rest as raw data
    typedef union packed {
        instrWord_t              instr;
        logic [`PAD_WIDTH-1:0]   raw;
    } padWord_t;

    // ========================================
    // Streams and buffer access
    // ========================================

    typedef struct packed {
        padWord_t   word;
        logic       last;
    } padBeat_t;

    typedef struct packed {
        logic                         en;
        logic [`BUF_ADDR_WIDTH-1:0]   addr;
        logic [`PAD_WIDTH-1:0]        data;
    } bufWrite_t;

    typedef struct packed {
        logic [`BUF_ADDR_WIDTH-1:0]   addr;
        logic [`CNT_WIDTH-1:0]        count;
    } readReq_t;

endpackage

`default_nettype wire

//--- source/padReceiver.sv
// Pad input packet decoder

`default_nettype none

`include "padLoader_defines.svh"

module padReceiver (
    input  logic                      clk,
    input  logic                      rst,
    input  padLoaderPkg::padBeat_t    padIn,
    input  logic                      padInVld,
    output logic                      padInRdy,
    input  logic                      busy,
    output padLoaderPkg::bufWrite_t   bufWr,
    output padLoaderPkg::readReq_t    readReq,
    output logic                      readStart
);
    import padLoaderPkg::*;

    typedef enum logic [1:0] {
        ST_INSTR,
        ST_WRITE,
        ST_DROP
    } rxState_e;

    rxState_e                     state;
    instrWord_t                   instr;
    logic                         isReadInstr;
    logic                         beatXfer;
    logic [`BUF_ADDR_WIDTH-1:0]   wrAddr;
    logic                         wrEn;
    logic [`BUF_ADDR_WIDTH-1:0]   wrAddrQ;
    logic [`PAD_WIDTH-1:0]        wrDataQ;
    readReq_t                     reqQ;

    // ========================================
    // Input handshake
    // ========================================

    assign instr       = padIn.word.instr;
    assign isReadInstr = (state == ST_INSTR) && (instr.op == OP_READ);

    // Only a read waiting on a busy transmitter stalls the pad
    assign padInRdy = !(padInVld && isReadInstr && busy);
    assign beatXfer = padInVld && padInRdy;

    // ========================================
    // Packet FSM
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_INSTR;
            wrEn      <= 1'b0;
            readStart <= 1'b0;
        end else begin
            wrEn      <= 1'b0;
            readStart <= 1'b0;
            if (beatXfer) begin
                case (state)
                    ST_INSTR: begin
                        if (instr.op == OP_READ) readStart <= 1'b1;
                        if (padIn.last) state <= ST_INSTR;
                        else if (instr.op == OP_WRITE) state <= ST_WRITE;
                        else state <= ST_DROP;
                    end
                    ST_WRITE: begin
                        wrEn <= 1'b1;
                        if (padIn.last) state <= ST_INSTR;
                    end
                    default: begin
                        if (padIn.last) state <= ST_INSTR;
                    end
                endcase
            end
        end
    end

    // Address counter wraps at the buffer end
    always_ff @(posedge clk) begin
        if (beatXfer && state == ST_INSTR) begin
            wrAddr <= instr.addr;
            if (instr.op == OP_READ) reqQ <= '{addr: instr.addr, count: instr.count};
        end else if (beatXfer && state == ST_WRITE) begin
            wrAddr  <= wrAddr + 1'b1;
            wrAddrQ <= wrAddr;
            wrDataQ <= padIn.word.raw;
        end
    end

    assign bufWr   = '{en: wrEn, addr: wrAddrQ, data: wrDataQ};
    assign readReq = reqQ;

endmodule

`default_nettype wire

//--- source/globalBuffer.sv
// Global buffer memory

`default_nettype none

`include "padLoader_defines.svh"

module globalBuffer (
    input  logic                         clk,
    input  padLoaderPkg::bufWrite_t      bufWr,
    input  logic                         rdEn,
    input  logic [`BUF_ADDR_WIDTH-1:0]   rdAddr,
    output logic [`PAD_WIDTH-1:0]        rdData
);

    logic [`PAD_WIDTH-1:0] mem [`BUF_DEPTH];

    // ========================================
    // Write port
    // ========================================

    always_ff @(posedge clk) begin
        if (bufWr.en) begin
            mem[bufWr.addr] <= bufWr.data;
        end
    end

    // ========================================
    // Read port
    // ========================================

    // Output holds its word until the next rdEn,
    // the transmitter parks one word here under back-pressure
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

//--- source/padTransmitter.sv
// Pad output run streamer

`default_nettype none

`include "padLoader_defines.svh"

module padTransmitter (
    input  logic                         clk,
    input  logic                         rst,
    input  padLoaderPkg::readReq_t       readReq,
    input  logic                         readStart,
    output logic                         busy,
    output logic                         rdEn,
    output logic [`BUF_ADDR_WIDTH-1:0]   rdAddr,
    input  logic [`PAD_WIDTH-1:0]        rdData,
    output padLoaderPkg::padBeat_t       padOut,
    output logic                         padOutVld,
    input  logic                         padOutRdy
);
    import padLoaderPkg::*;

    logic                         issuing;
    logic [`CNT_WIDTH-1:0]        reqLeft;
    logic [`BUF_ADDR_WIDTH-1:0]   rdAddrQ;
    logic                         pendRd;
    logic                         pendLast;
    logic                         qVld;
    readReq_t                     qReq;
    padBeat_t                     outBeat;
    logic                         outVld;
    logic                         outFire;
    logic                         outFree;
    logic                         loadOut;
    logic                         runDone;
    logic                         startNew;
    logic                         startQueued;

    assign outFire     = outVld && padOutRdy;
    assign outFree     = !outVld || outFire;
    assign loadOut     = pendRd && outFree;
    assign rdEn        = issuing && outFree;
    assign runDone     = outFire && outBeat.last;
    assign startNew    = readStart && !busy;
    // A read can land in the first busy cycle, it waits for the current run
    assign startQueued = runDone && qVld;

    // ========================================
    // Control
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            issuing <= 1'b0;
            pendRd  <= 1'b0;
            outVld  <= 1'b0;
            qVld    <= 1'b0;
        end else begin
            if (startNew) busy <= 1'b1;
            else if (runDone && !qVld) busy <= 1'b0;
            if (startNew || startQueued) issuing <= 1'b1;
            else if (rdEn && reqLeft == '0) issuing <= 1'b0;
            pendRd <= rdEn || (pendRd && !loadOut);
            if (loadOut) outVld <= 1'b1;
            else if (outFire) outVld <= 1'b0;
            if (readStart && busy) qVld <= 1'b1;
            else if (startQueued) qVld <= 1'b0;
        end
    end

    // ========================================
    // Address, count and output word
    // ========================================

    always_ff @(posedge clk) begin
        if (startNew) begin
            rdAddrQ <= readReq.addr;
            reqLeft <= readReq.count;
        end else if (startQueued) begin
            rdAddrQ <= qReq.addr;
            reqLeft <= qReq.count;
        end else if (rdEn) begin
            rdAddrQ <= rdAddrQ + 1'b1;
            reqLeft <= reqLeft - 1'b1;
        end
        if (rdEn) pendLast <= (reqLeft == '0);
        if (readStart && busy) qReq <= readReq;
        if (loadOut) begin
            outBeat.word.raw <= rdData;
            outBeat.last     <= pendLast;
        end
    end

    assign rdAddr    = rdAddrQ;
    assign padOut    = outBeat;
    assign padOutVld = outVld;

endmodule

`default_nettype wire

//--- source/padLoaderTop.sv
// Pad loader top level

`default_nettype none

`include "padLoader_defines.svh"

module padLoaderTop (
    input  logic                       clk,
    input  logic                       rst,
    input  padLoaderPkg::padBeat_t     padIn,
    input  logic                       padInVld,
    output logic                       padInRdy,
    output padLoaderPkg::padBeat_t     padOut,
    output logic                       padOutVld,
    input  logic                       padOutRdy,
    output logic                       datOe
);
    import padLoaderPkg::*;

    bufWrite_t               bufWr;
    readReq_t                readReq;
    logic                    readStart;
    logic                    busy;
    logic                    rdEn;
    logic [`BUF_ADDR_WIDTH-1:0] rdAddr;
    logic [`PAD_WIDTH-1:0]   rdData;

    // ========================================
    // Receive, store, transmit
    // ========================================

    padReceiver u_padReceiver (
        .clk       (clk),
        .rst       (rst),
        .padIn     (padIn),
        .padInVld  (padInVld),
        .padInRdy  (padInRdy),
        .busy      (busy),
        .bufWr     (bufWr),
        .readReq   (readReq),
        .readStart (readStart)
    );

    globalBuffer u_globalBuffer (
        .clk    (clk),
        .bufWr  (bufWr),
        .rdEn   (rdEn),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

    padTransmitter u_padTransmitter (
        .clk       (clk),
        .rst       (rst),
        .readReq   (readReq),
        .readStart (readStart),
        .busy      (busy),
        .rdEn      (rdEn),
        .rdAddr    (rdAddr),
        .rdData    (rdData),
        .padOut    (padOut),
        .padOutVld (padOutVld),
        .padOutRdy (padOutRdy)
    );

    // Pad drives outward for the whole read run
    assign datOe = busy;

endmodule

`default_nettype wire

//--- bench/padLoader_props.sv
// Pad port assertions

`default_nettype none

module padLoader_props (
    input logic                     clk,
    input logic                     rst,
    input padLoaderPkg::padBeat_t   padOut,
    input logic                     padOutVld,
    input logic                     padOutRdy,
    input logic                     padInRdy,
    input logic                     datOe
);

    // ========================================
    // Output stream
    // ========================================

    outVldNeedsOe: assert property (@(posedge clk) disable iff (rst)
        padOutVld |-> datOe)
        else $error("padOutVld high while datOe is low");

    // Stalled beat holds until taken
    outHoldsUnderStall: assert property (@(posedge clk) disable iff (rst)
        padOutVld && !padOutRdy |=> padOutVld && $stable(padOut))
        else $error("padOut changed or dropped while stalled");

    // ========================================
    // Input stream
    // ========================================

    inRdyWhenIdle: assert property (@(posedge clk) disable iff (rst)
        !datOe |-> padInRdy)
        else $error("padInRdy low while no read run is active");

endmodule

bind padLoaderTop padLoader_props u_props (
    .clk       (clk),
    .rst       (rst),
    .padOut    (padOut),
    .padOutVld (padOutVld),
    .padOutRdy (padOutRdy),
    .padInRdy  (padInRdy),
    .datOe     (datOe)
);

`default_nettype wire

//--- bench/padLoaderTb.sv
// Pad loader testbench

`default_nettype none

`include "padLoader_defines.svh"

module padLoaderTb;
    import padLoaderPkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int NUM_ROUNDS  = 40;
    localparam logic [31:0] SEED = 32'h2d9c_403d;
    // Fill, final readback, and at most six packets per round
    localparam int NUM_PACKETS   = NUM_ROUNDS * 6 + 2;
    localparam int WATCHDOG_TIME = NUM_PACKETS * 40 * CLK_PERIOD;

    logic                    clk;
    logic                    rst;
    padBeat_t                padIn;
    logic                    padInVld;
    logic                    padInRdy;
    padBeat_t                padOut;
    logic                    padOutVld;
    logic                    padOutRdy;
    logic                    datOe;

    logic [31:0]             stimState;
    logic [31:0]             rdyState;
    logic [`PAD_WIDTH-1:0]   model [`BUF_DEPTH];
    // Expected output beats, data above the last flag
    logic [`PAD_WIDTH:0]     expQ [$];
    int                      errors;
    int                      checks;

    padLoaderTop i_dut (
        .clk       (clk),
        .rst       (rst),
        .padIn     (padIn),
        .padInVld  (padInVld),
        .padInRdy  (padInRdy),
        .padOut    (padOut),
        .padOutVld (padOutVld),
        .padOutRdy (padOutRdy),
        .datOe     (datOe)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================
    // Helpers
    // ========================================

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] stimRand();
        stimState = xorshift(stimState);
        return stimState;
    endfunction

    function automatic logic [`PAD_WIDTH-1:0] makeInstr(input logic [1:0] op,
                                                        input logic [7:0] addr,
                                                        input logic [7:0] count);
        instrWord_t instr;
        instr = '{op: opcode_e'(op), reserved: '0, addr: addr, count: count};
        return instr;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] expVal,
                              input logic [63:0] gotVal);
        checks++;
        assert (gotVal === expVal) else begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, expVal, gotVal);
            errors++;
        end
    endtask

    // Called at a falling edge, returns at the falling edge after the transfer
    task automatic sendBeat(input logic [`PAD_WIDTH-1:0] word, input logic last);
        logic accepted;
        accepted = 1'b0;
        while (stimRand() % 4 == 0) begin
            padInVld = 1'b0;
            @(negedge clk);
        end
        padIn.word.raw = word;
        padIn.last     = last;
        padInVld       = 1'b1;
        while (!accepted) begin
            #1;
            accepted = padInRdy;
            @(negedge clk);
        end
        padInVld = 1'b0;
    endtask

    task automatic writePacket(input logic [7:0] addr, input int len);
        logic [`PAD_WIDTH-1:0] data;
        logic [7:0]            a;
        int                    i;
        a = addr;
        sendBeat(makeInstr(2'd0, addr, 8'd0), len == 0);
        for (i = 0; i < len; i++) begin
            data     = stimRand();
            model[a] = data;
            sendBeat(data, i == len - 1);
            a = a + 8'd1;
        end
    endtask

    task automatic readPacket(input logic [7:0] addr, input logic [7:0] count);
        logic [7:0] a;
        int         i;
        a = addr;
        for (i = 0; i <= int'(count); i++) begin
            expQ.push_back({model[a], i == int'(count)});
            a = a + 8'd1;
        end
        sendBeat(makeInstr(2'd1, addr, count), 1'b1);
    endtask

    // Opcode 2 or 3 with random data, nothing may reach the buffer
    task automatic dropPacket(input int len);
        logic [31:0] r;
        int          i;
        r = stimRand();
        sendBeat(makeInstr({1'b1, r[0]}, r[15:8], r[23:16]), len == 0);
        for (i = 0; i < len; i++) begin
            sendBeat(stimRand(), i == len - 1);
        end
    endtask

    task automatic drainReads();
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        checkValue("datOe", 64'd0, datOe);
    endtask

    // ========================================
    // Output side
    // ========================================

    always @(negedge clk) begin : outMonitor
        logic [`PAD_WIDTH:0] expBeat;
        rdyState  = xorshift(rdyState);
        padOutRdy = (rdyState % 4 != 0);
        // Vld and data are stable here, so the beat moves at the next rising edge
        if (rst === 1'b0 && padOutVld && padOutRdy) begin
            checkValue("datOe", 64'd1, datOe);
            if (expQ.size() == 0) begin
                $display("Output beat %h at %0t arrived with no read pending", padOut, $time);
                errors++;
            end else begin
                expBeat = expQ.pop_front();
                checkValue("padOut.word", expBeat[`PAD_WIDTH:1], padOut.word.raw);
                checkValue("padOut.last", expBeat[0], padOut.last);
            end
        end
    end

    // ========================================
    // Stimulus and verdict
    // ========================================

    initial begin
        int          round;
        int          n;
        int          k;
        logic [31:0] r;
        logic [7:0]  addr;
        clk       = 1'b0;
        rst       = 1'b1;
        padIn     = '0;
        padInVld  = 1'b0;
        padOutRdy = 1'b0;
        stimState = SEED;
        rdyState  = ~SEED;
        errors    = 0;
        checks    = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        checkValue("datOe", 64'd0, datOe);
        checkValue("padOutVld", 64'd0, padOutVld);
        checkValue("padInRdy", 64'd1, padInRdy);

        // Fill every word once
        writePacket(8'd0, `BUF_DEPTH);
        for (round = 0; round < NUM_ROUNDS; round++) begin
            n = 1 + stimRand() % 3;
            for (k = 0; k < n; k++) begin
                r = stimRand();
                // Every fourth round starts near the top so runs wrap
                addr = (round % 4 == 0) ? 8'd248 + {5'd0, r[2:0]} : r[7:0];
                if (r[31:30] == 2'b11) dropPacket(r[11:8] % 6);
                else writePacket(addr, r[19:16] % 12);
            end
            // Back-to-back reads, the later ones stall on busy
            n = 1 + stimRand() % 3;
            for (k = 0; k < n; k++) begin
                r = stimRand();
                addr = (round % 4 == 0) ? 8'd248 + {5'd0, r[2:0]} : r[7:0];
                readPacket(addr, {3'd0, r[12:8]});
            end
            drainReads();
        end
        // Whole buffer, dropped packets must not show up anywhere
        readPacket(8'd0, 8'd255);
        drainReads();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_TIME);
        $display("Timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+source
source/padLoaderPkg.sv
source/padReceiver.sv
source/globalBuffer.sv
source/padTransmitter.sv
source/padLoaderTop.sv
bench/padLoader_props.sv
bench/padLoaderTb.sv

//--- run.sh
#!/bin/sh
# Build and run the pad loader simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module padLoaderTb -f build.f -o padLoaderSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/padLoaderSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    exit 1
fi
if ! grep -q "test passed" "$LOG"; then
    echo "No verdict found in $LOG"
    exit 1
fi
exit 0
